/* Bender.yml */
package:
  name: conv_layer

sources:
  - files:
      - logic/cnn_geom_pkg.sv
      - logic/cnn_ctrl_pkg.sv
      - logic/sample_ram.sv
      - logic/weight_loader.sv
      - logic/conv_engine.sv
      - logic/result_bank.sv
      - logic/flat_streamer.sv
      - logic/conv_layer_top.sv
  - target: test
    files:
      - testbench/conv_layer_asserts.sv
      - testbench/conv_layer_tb.sv

/* conv_layer.f */
logic/cnn_geom_pkg.sv
logic/cnn_ctrl_pkg.sv
logic/sample_ram.sv
logic/weight_loader.sv
logic/conv_engine.sv
logic/result_bank.sv
logic/flat_streamer.sv
logic/conv_layer_top.sv
testbench/conv_layer_asserts.sv
testbench/conv_layer_tb.sv

/* logic/cnn_ctrl_pkg.sv */
`default_nettype none

package cnn_ctrl_pkg;

    // engine phases
    // run issues tap addresses, finish waits for the last vector,
    // hold keeps the engine parked until start is released
    typedef enum logic [1:0] {
        ENG_IDLE   = 2'd0,
        ENG_RUN    = 2'd1,
        ENG_FINISH = 2'd2,
        ENG_HOLD   = 2'd3
    } engine_state_e;

    // ping-pong result store
    localparam int BANK_SLOTS = 2;

endpackage

`default_nettype wire

/* logic/cnn_geom_pkg.sv */
`default_nettype none

package cnn_geom_pkg;

    // datapath word and bus address widths
    localparam int DATA_W = 16;
    localparam int ADDR_W = 16;

    // square kernel, taps stored row-major
    localparam int KERNEL_DIM  = 3;
    localparam int KERNEL_TAPS = KERNEL_DIM * KERNEL_DIM;

    // wide enough for a tap index up to KERNEL_TAPS-1
    localparam int TAP_W = 4;

    // load bus and output stream word
    typedef logic signed [DATA_W-1:0] word_t;

    // image sample
    typedef logic signed [DATA_W-1:0] pixel_t;

    // kernel coefficient
    typedef logic signed [DATA_W-1:0] weight_t;

    typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

/* logic/conv_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_engine #(
    parameter int IMG_SIZE    = 18,
    parameter int NUM_FILTERS = 6
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  i_start,
    input  cnn_geom_pkg::pixel_t  i_pixel,
    input  cnn_geom_pkg::weight_t i_weights [NUM_FILTERS],
    output cnn_geom_pkg::addr_t   o_img_raddr,
    output cnn_geom_pkg::addr_t   o_tap,
    output logic                  o_wr,
    output cnn_geom_pkg::addr_t   o_pixel_idx,
    output cnn_geom_pkg::word_t   o_sums [NUM_FILTERS]
);

    import cnn_geom_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int OUT_SIZE = IMG_SIZE - KERNEL_DIM + 1;
    localparam int NUM_PIX  = OUT_SIZE * OUT_SIZE;

    engine_state_e    state;
    addr_t            row;
    addr_t            col;
    addr_t            pix;
    addr_t            acc_pix;
    logic [TAP_W-1:0] tap;
    logic [TAP_W-1:0] tap_r;
    logic [TAP_W-1:0] tap_c;
    logic             issue;
    logic             last_tap;
    logic             last_pix;
    logic             acc_v;
    logic             acc_first;
    logic             acc_last;

    assign issue    = (state == ENG_RUN);
    assign last_tap = (tap == TAP_W'(KERNEL_TAPS - 1));
    assign last_pix = (pix == addr_t'(NUM_PIX - 1));

    // window origin plus tap offset
    assign o_img_raddr = addr_t'((row + tap_r) * IMG_SIZE + col + tap_c);
    assign o_tap       = addr_t'(tap);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ENG_IDLE;
            row   <= '0;
            col   <= '0;
            pix   <= '0;
            tap   <= '0;
            tap_r <= '0;
            tap_c <= '0;
        end else if (!i_start) begin
            state <= ENG_IDLE;
            row   <= '0;
            col   <= '0;
            pix   <= '0;
            tap   <= '0;
            tap_r <= '0;
            tap_c <= '0;
        end else begin
            case (state)
                ENG_IDLE: state <= ENG_RUN;
                ENG_RUN: begin
                    if (last_tap) begin
                        tap   <= '0;
                        tap_r <= '0;
                        tap_c <= '0;
                        if (last_pix) begin
                            state <= ENG_FINISH;
                        end else begin
                            pix <= pix + 1'b1;
                            if (col == addr_t'(OUT_SIZE - 1)) begin
                                col <= '0;
                                row <= row + 1'b1;
                            end else begin
                                col <= col + 1'b1;
                            end
                        end
                    end else begin
                        tap <= tap + 1'b1;
                        if (tap_c == TAP_W'(KERNEL_DIM - 1)) begin
                            tap_c <= '0;
                            tap_r <= tap_r + 1'b1;
                        end else begin
                            tap_c <= tap_c + 1'b1;
                        end
                    end
                end
                // last vector leaves two cycles after its last address
                ENG_FINISH: if (o_wr) state <= ENG_HOLD;
                default: state <= ENG_HOLD;
            endcase
        end
    end

    // tap flags follow the memory read latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc_v     <= 1'b0;
            acc_first <= 1'b0;
            acc_last  <= 1'b0;
            o_wr      <= 1'b0;
        end else begin
            acc_v     <= issue;
            acc_first <= issue && (tap == '0);
            acc_last  <= issue && last_tap;
            o_wr      <= acc_last;
        end
    end

    // 16-bit wraparound accumulate, one lane per filter
    always_ff @(posedge clk) begin
        if (issue && last_tap) begin
            acc_pix <= pix;
        end
        if (acc_last) begin
            o_pixel_idx <= acc_pix;
        end
        if (acc_v) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                o_sums[f] <= (acc_first ? word_t'(0) : o_sums[f])
                             + word_t'(i_pixel * i_weights[f]);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/conv_layer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer_top #(
    parameter int IMG_SIZE    = 18,
    parameter int NUM_FILTERS = 6
) (
    input  logic                clk,
    input  logic                reset_n,
    input  cnn_geom_pkg::word_t i_data,
    input  cnn_geom_pkg::addr_t i_addr,
    input  logic                i_we,
    input  logic                i_img_input,
    input  logic                i_conv_weight,
    input  logic                i_start,
    output cnn_geom_pkg::word_t o_flat,
    output cnn_geom_pkg::addr_t o_addr,
    output logic                o_we,
    output logic                o_done
);

    import cnn_geom_pkg::*;

    logic                   img_we;
    addr_t                  img_waddr;
    pixel_t                 img_wdata;
    pixel_t                 img_rdata;
    logic [NUM_FILTERS-1:0] w_we;
    addr_t                  w_tap;
    weight_t                w_wdata;
    weight_t                w_rdata [NUM_FILTERS];
    addr_t                  eng_raddr;
    addr_t                  eng_tap;
    addr_t                  eng_pix;
    logic                   eng_wr;
    word_t                  eng_sums [NUM_FILTERS];
    logic                   bank_valid;
    logic                   release_slot;
    addr_t                  bank_pix;
    word_t                  bank_sums [NUM_FILTERS];

    weight_loader #(.NUM_FILTERS(NUM_FILTERS)) u_loader (
        .clk(clk), .reset_n(reset_n), .i_data(i_data), .i_addr(i_addr), .i_we(i_we),
        .i_img_input(i_img_input), .i_conv_weight(i_conv_weight), .i_clear(o_done),
        .o_img_we(img_we), .o_img_addr(img_waddr), .o_img_data(img_wdata),
        .o_w_we(w_we), .o_w_tap(w_tap), .o_w_data(w_wdata)
    );

    // memory port goes to the loader only while it writes
    sample_ram #(.DEPTH(IMG_SIZE * IMG_SIZE), .word_type(pixel_t)) u_image (
        .clk(clk), .i_we(img_we), .i_addr(img_we ? img_waddr : eng_raddr),
        .i_wdata(img_wdata), .o_rdata(img_rdata)
    );

    for (genvar f = 0; f < NUM_FILTERS; f++) begin : g_kernel
        sample_ram #(.DEPTH(KERNEL_TAPS), .word_type(weight_t)) u_kernel (
            .clk(clk), .i_we(w_we[f]), .i_addr(w_we[f] ? w_tap : eng_tap),
            .i_wdata(w_wdata), .o_rdata(w_rdata[f])
        );
    end

    conv_engine #(.IMG_SIZE(IMG_SIZE), .NUM_FILTERS(NUM_FILTERS)) u_engine (
        .clk(clk), .reset_n(reset_n), .i_start(i_start), .i_pixel(img_rdata),
        .i_weights(w_rdata), .o_img_raddr(eng_raddr), .o_tap(eng_tap), .o_wr(eng_wr),
        .o_pixel_idx(eng_pix), .o_sums(eng_sums)
    );

    result_bank #(.NUM_FILTERS(NUM_FILTERS)) u_bank (
        .clk(clk), .reset_n(reset_n), .i_wr(eng_wr), .i_pixel_idx(eng_pix),
        .i_sums(eng_sums), .i_release(release_slot), .o_valid(bank_valid),
        .o_pixel_idx(bank_pix), .o_sums(bank_sums)
    );

    flat_streamer #(.IMG_SIZE(IMG_SIZE), .NUM_FILTERS(NUM_FILTERS)) u_streamer (
        .clk(clk), .reset_n(reset_n), .i_start(i_start), .i_valid(bank_valid),
        .i_pixel_idx(bank_pix), .i_sums(bank_sums), .o_release(release_slot),
        .o_flat(o_flat), .o_addr(o_addr), .o_we(o_we), .o_done(o_done)
    );

endmodule

`default_nettype wire

/* logic/flat_streamer.sv */
`timescale 1ns/1ps
`default_nettype none

module flat_streamer #(
    parameter int IMG_SIZE    = 18,
    parameter int NUM_FILTERS = 6
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_start,
    input  logic                i_valid,
    input  cnn_geom_pkg::addr_t i_pixel_idx,
    input  cnn_geom_pkg::word_t i_sums [NUM_FILTERS],
    output logic                o_release,
    output cnn_geom_pkg::word_t o_flat,
    output cnn_geom_pkg::addr_t o_addr,
    output logic                o_we,
    output logic                o_done
);

    import cnn_geom_pkg::*;

    localparam int OUT_SIZE = IMG_SIZE - KERNEL_DIM + 1;
    localparam int PLANE    = OUT_SIZE * OUT_SIZE;
    localparam int TOTAL    = NUM_FILTERS * PLANE;
    localparam int FW       = $clog2(NUM_FILTERS + 1);

    logic [FW-1:0] filt;
    addr_t         word_cnt;
    logic          sent;

    // free the slot while its last word goes out
    assign o_release = i_valid && (filt == FW'(NUM_FILTERS - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            filt <= '0;
            o_we <= 1'b0;
        end else begin
            o_we <= i_valid;
            if (i_valid) begin
                filt <= o_release ? '0 : filt + 1'b1;
            end
        end
    end

    // filter-major output planes
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_flat <= i_sums[filt];
            o_addr <= addr_t'(filt * PLANE + i_pixel_idx);
        end
    end

    // single done per run, rearmed by start going low
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            word_cnt <= '0;
            sent     <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!i_start) begin
                word_cnt <= '0;
                sent     <= 1'b0;
            end else begin
                if (i_valid) begin
                    word_cnt <= word_cnt + 1'b1;
                end
                if (o_we && !sent && (word_cnt == addr_t'(TOTAL))) begin
                    o_done <= 1'b1;
                    sent   <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/result_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module result_bank #(
    parameter int NUM_FILTERS = 6
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_wr,
    input  cnn_geom_pkg::addr_t i_pixel_idx,
    input  cnn_geom_pkg::word_t i_sums [NUM_FILTERS],
    input  logic                i_release,
    output logic                o_valid,
    output cnn_geom_pkg::addr_t o_pixel_idx,
    output cnn_geom_pkg::word_t o_sums [NUM_FILTERS]
);

    import cnn_geom_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int PW = (BANK_SLOTS > 1) ? $clog2(BANK_SLOTS) : 1;

    logic [BANK_SLOTS-1:0] full;
    logic [PW-1:0]         wr_ptr;
    logic [PW-1:0]         rd_ptr;
    addr_t                 slot_pix  [BANK_SLOTS];
    word_t                 slot_sums [BANK_SLOTS][NUM_FILTERS];

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(BANK_SLOTS - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full   <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_release) begin
                full[rd_ptr] <= 1'b0;
                rd_ptr       <= next_ptr(rd_ptr);
            end
            if (i_wr) begin
                full[wr_ptr] <= 1'b1;
                wr_ptr       <= next_ptr(wr_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr) begin
            slot_pix[wr_ptr]  <= i_pixel_idx;
            slot_sums[wr_ptr] <= i_sums;
        end
    end

    // oldest full slot
    assign o_valid     = full[rd_ptr];
    assign o_pixel_idx = slot_pix[rd_ptr];
    assign o_sums      = slot_sums[rd_ptr];

endmodule

`default_nettype wire

/* logic/sample_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_ram #(
    parameter int  DEPTH     = 9,
    parameter type word_type = cnn_geom_pkg::word_t
) (
    input  logic                clk,
    input  logic                i_we,
    input  cnn_geom_pkg::addr_t i_addr,
    input  word_type            i_wdata,
    output word_type            o_rdata
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_type      mem [DEPTH];
    logic [AW-1:0] idx;

    // upper address bits are not decoded
    assign idx = i_addr[AW-1:0];

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[idx] <= i_wdata;
        end
        o_rdata <= mem[idx];
    end

endmodule

`default_nettype wire

/* logic/weight_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_loader #(
    parameter int NUM_FILTERS = 6
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  cnn_geom_pkg::word_t     i_data,
    input  cnn_geom_pkg::addr_t     i_addr,
    input  logic                    i_we,
    input  logic                    i_img_input,
    input  logic                    i_conv_weight,
    input  logic                    i_clear,
    output logic                    o_img_we,
    output cnn_geom_pkg::addr_t     o_img_addr,
    output cnn_geom_pkg::pixel_t    o_img_data,
    output logic [NUM_FILTERS-1:0]  o_w_we,
    output cnn_geom_pkg::addr_t     o_w_tap,
    output cnn_geom_pkg::weight_t   o_w_data
);

    import cnn_geom_pkg::*;

    localparam int FW = $clog2(NUM_FILTERS + 1);

    logic [FW-1:0]    filt_cnt;
    logic [TAP_W-1:0] tap_cnt;
    logic             w_take;

    // image mode owns the bus, address taken as given
    assign o_img_we   = i_img_input & i_we;
    assign o_img_addr = i_addr;
    assign o_img_data = pixel_t'(i_data);

    // weight mode, bus address ignored, writes past the last filter dropped
    assign w_take = !i_img_input && i_conv_weight && i_we && (filt_cnt < FW'(NUM_FILTERS));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            filt_cnt <= '0;
            tap_cnt  <= '0;
        end else if (i_clear) begin
            filt_cnt <= '0;
            tap_cnt  <= '0;
        end else if (w_take) begin
            if (tap_cnt == TAP_W'(KERNEL_TAPS - 1)) begin
                tap_cnt  <= '0;
                filt_cnt <= filt_cnt + 1'b1;
            end else begin
                tap_cnt <= tap_cnt + 1'b1;
            end
        end
    end

    // one strobe per kernel memory, a cycle behind the bus
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_w_we <= '0;
        end else begin
            o_w_we <= '0;
            if (w_take) begin
                o_w_we[filt_cnt] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_take) begin
            o_w_tap  <= addr_t'(tap_cnt);
            o_w_data <= weight_t'(i_data);
        end
    end

endmodule

`default_nettype wire

/* testbench/conv_layer_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer_asserts (
    input logic       clk,
    input logic       reset_n,
    input logic       i_wr,
    input logic       i_slot_full,
    input logic [1:0] i_state,
    input logic       i_out_we
);

    import cnn_ctrl_pkg::*;

    int fail_cnt = 0;

    // the streamer must drain a slot before the engine comes back to it
    slot_free_on_write: assert property (
        @(posedge clk) disable iff (!reset_n) i_wr |-> !i_slot_full
    ) else begin
        $error("result slot written while still full");
        fail_cnt++;
    end

    // phases step forward one at a time or fall back to idle
    state_legal: assert property (
        @(posedge clk) disable iff (!reset_n)
        !$isunknown(i_state) && (i_state == ENG_IDLE || i_state == $past(i_state)
                                 || i_state == $past(i_state) + 2'd1)
    ) else begin
        $error("engine state took an illegal step");
        fail_cnt++;
    end

    quiet_in_reset: assert property (
        @(posedge clk) !reset_n |-> !i_out_we
    ) else begin
        $error("write strobe high during reset");
        fail_cnt++;
    end

endmodule

bind result_bank conv_layer_asserts slot_chk (
    .clk(clk), .reset_n(reset_n), .i_wr(i_wr), .i_slot_full(full[wr_ptr]),
    .i_state(2'd0), .i_out_we(1'b0)
);

bind conv_engine conv_layer_asserts state_chk (
    .clk(clk), .reset_n(reset_n), .i_wr(1'b0), .i_slot_full(1'b0),
    .i_state(state), .i_out_we(o_wr)
);

bind flat_streamer conv_layer_asserts strobe_chk (
    .clk(clk), .reset_n(reset_n), .i_wr(1'b0), .i_slot_full(1'b0),
    .i_state(2'd0), .i_out_we(o_we)
);

`default_nettype wire

/* testbench/conv_layer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer_tb;

    import cnn_geom_pkg::*;

    localparam int IMG_SIZE        = 8;
    localparam int NUM_FILTERS     = 6;
    localparam int OUT_SIZE        = IMG_SIZE - KERNEL_DIM + 1;
    localparam int PLANE           = OUT_SIZE * OUT_SIZE;
    localparam int TOTAL           = NUM_FILTERS * PLANE;
    localparam int IMG_WORDS       = IMG_SIZE * IMG_SIZE;
    localparam int W_WORDS         = NUM_FILTERS * KERNEL_TAPS;
    localparam int EXTRA_W         = 5;
    localparam int REWRITES        = 8;
    localparam int NUM_RUNS        = 2;
    localparam int CLK_HALF        = 10;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 5;
    localparam int IDLE_CYCLES     = 20;
    localparam int RUN_CYCLES      = PLANE * KERNEL_TAPS + 100;
    localparam int LOAD_CYCLES     = IMG_WORDS + W_WORDS + EXTRA_W + REWRITES + 20;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (RUN_CYCLES + LOAD_CYCLES)
                                     + RESET_CYCLES + IDLE_CYCLES;
    localparam logic [31:0] SEED   = 32'hd8a8_7eda;

    logic  clk;
    logic  reset_n;
    word_t i_data;
    addr_t i_addr;
    logic  i_we;
    logic  i_img_input;
    logic  i_conv_weight;
    logic  i_start;
    word_t o_flat;
    addr_t o_addr;
    logic  o_we;
    logic  o_done;

    // testbench copies of what was loaded
    word_t img_ref [IMG_WORDS];
    word_t w_ref   [NUM_FILTERS][KERNEL_TAPS];
    int    word_idx = 0;
    int    done_cnt = 0;
    bit    run_done = 1'b0;
    bit    prev_we  = 1'b0;

    conv_layer_top #(.IMG_SIZE(IMG_SIZE), .NUM_FILTERS(NUM_FILTERS)) dut_i (
        .clk(clk), .reset_n(reset_n), .i_data(i_data), .i_addr(i_addr), .i_we(i_we),
        .i_img_input(i_img_input), .i_conv_weight(i_conv_weight), .i_start(i_start),
        .o_flat(o_flat), .o_addr(o_addr), .o_we(o_we), .o_done(o_done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
            stop_on_failure();
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before all runs finished");
    end

    function automatic word_t random_word();
        return word_t'($urandom);
    endfunction

    // valid 3x3 convolution into filter-major planes with 16-bit wraparound
    function automatic word_t expected_word(input addr_t addr);
        int     filt;
        int     pix;
        int     row;
        int     col;
        longint acc;
        filt = addr / PLANE;
        pix  = addr % PLANE;
        row  = pix / OUT_SIZE;
        col  = pix % OUT_SIZE;
        acc  = 0;
        for (int tr = 0; tr < KERNEL_DIM; tr++) begin
            for (int tc = 0; tc < KERNEL_DIM; tc++) begin
                acc += longint'(img_ref[(row + tr) * IMG_SIZE + col + tc])
                       * longint'(w_ref[filt][tr * KERNEL_DIM + tc]);
            end
        end
        return word_t'(acc);
    endfunction

    function automatic int assert_failures();
        return dut_i.u_bank.slot_chk.fail_cnt + dut_i.u_engine.state_chk.fail_cnt
               + dut_i.u_streamer.strobe_chk.fail_cnt;
    endfunction

    task automatic bus_write(input logic img, input logic wgt, input addr_t addr,
                             input word_t data);
        @(posedge clk);
        #DRIVE_DELAY;
        i_img_input   = img;
        i_conv_weight = wgt;
        i_addr        = addr;
        i_data        = data;
        i_we          = 1'b1;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        #DRIVE_DELAY;
        i_we          = 1'b0;
        i_img_input   = 1'b0;
        i_conv_weight = 1'b0;
    endtask

    // weight select held high too so the image mode must win
    task automatic load_image();
        word_t data;
        for (int a = 0; a < IMG_WORDS; a++) begin
            data       = random_word();
            img_ref[a] = data;
            bus_write(1'b1, 1'b1, addr_t'(a), data);
        end
        bus_idle();
    endtask

    // words past the last filter must be dropped
    task automatic load_weights(input int extra);
        word_t data;
        for (int n = 0; n < W_WORDS + extra; n++) begin
            data = random_word();
            if (n < W_WORDS) begin
                w_ref[n / KERNEL_TAPS][n % KERNEL_TAPS] = data;
            end
            bus_write(1'b0, 1'b1, addr_t'($urandom), data);
        end
        bus_idle();
    endtask

    task automatic rewrite_pixels();
        int    a;
        word_t data;
        for (int n = 0; n < REWRITES; n++) begin
            a          = $urandom % IMG_WORDS;
            data       = random_word();
            img_ref[a] = data;
            bus_write(1'b1, 1'b1, addr_t'(a), data);
        end
        bus_idle();
    endtask

    task automatic run_layer();
        int start_cnt;
        int waited;
        start_cnt = done_cnt;
        waited    = 0;
        @(posedge clk);
        #DRIVE_DELAY;
        i_start = 1'b1;
        while (done_cnt == start_cnt) begin
            @(posedge clk);
            waited++;
            if (waited > RUN_CYCLES) begin
                abort_run("o_done did not arrive within the expected run time");
            end
        end
        // linger in hold to catch stray words or a second done
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        i_start = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    // output checks on the falling edge
    always @(negedge clk) begin
        int pix;
        int filt;
        if (reset_n) begin
            if (assert_failures() != 0) begin
                abort_run("a bound assertion failed");
            end
            if (!i_start) begin
                if (o_we || o_done) begin
                    abort_run("output activity while i_start is low");
                end
                word_idx = 0;
                run_done = 1'b0;
                prev_we  = 1'b0;
            end else begin
                if (o_we) begin
                    if (run_done || word_idx >= TOTAL) begin
                        abort_run("extra output word after the run was complete");
                    end
                    pix  = word_idx / NUM_FILTERS;
                    filt = word_idx % NUM_FILTERS;
                    check_value("o_addr", o_addr, filt * PLANE + pix);
                    check_value("o_flat", o_flat, expected_word(o_addr));
                    word_idx++;
                end
                if (o_done) begin
                    if (run_done) begin
                        abort_run("o_done pulsed twice in one run");
                    end
                    if (word_idx != TOTAL || !prev_we) begin
                        abort_run("o_done did not come right after the last output word");
                    end
                    run_done = 1'b1;
                    done_cnt++;
                end
                prev_we = o_we;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset_n       = 1'b0;
        i_data        = '0;
        i_addr        = '0;
        i_we          = 1'b0;
        i_img_input   = 1'b0;
        i_conv_weight = 1'b0;
        i_start       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;

        // quiet outputs without a start
        repeat (IDLE_CYCLES) @(posedge clk);

        load_image();
        load_weights(EXTRA_W);
        rewrite_pixels();
        repeat (3) @(posedge clk);
        run_layer();

        // counters were cleared by done so the new set starts at filter 0 tap 0
        load_weights(2);
        repeat (3) @(posedge clk);
        run_layer();

        if (done_cnt == NUM_RUNS && assert_failures() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d of %0d runs done, %0d assertion failures",
                                done_cnt, NUM_RUNS, assert_failures()));
        end
    end

endmodule

`default_nettype wire
